//--- logic/bus_word_pkg.sv
package bus_word_pkg;

    // Width of the shared data bus
    localparam int data_width = 32;

    // Largest device count that the address map can name
    localparam int max_devices = 8;

    // Device field at the top of a virtual address
    localparam int dev_index_width = 3;

    // Offset inside the addressed device
    localparam int offset_width = data_width - dev_index_width;

    // Virtual address as a master puts it on the bus
    typedef struct packed {
        logic [dev_index_width-1:0] dev_index;
        logic [offset_width-1:0]    offset;
    } virt_addr_t;

    // One bus word, seen as plain data or as an address.
    // The translator reads the addr view, everything else moves data
    typedef union packed {
        logic [data_width-1:0] data;
        virt_addr_t            addr;
    } bus_word_t;

endpackage

//--- logic/bus_ctrl_pkg.sv
package bus_ctrl_pkg;

    // Width of the per-device control word
    localparam int ctrl_width = 8;

    // Control word layout from the msb down
    // wait_flag sits in bit 0 and we in bit 1
    typedef struct packed {
        logic [2:0] reserved;
        logic [2:0] burst;
        logic       we;
        logic       wait_flag;
    } ctrl_fields_t;

    // Transfer sequencer states
    typedef enum logic [2:0] {
        // Waiting for any request
        idle      = 3'd0,
        // Master acknowledged, attributes latched here
        ack       = 3'd1,
        // Physical address on the bus
        addr      = 3'd2,
        // Slave selected, address held, control forced
        ack_slave = 3'd3,
        // Data moving until the master drops req
        busy      = 3'd4,
        // Grant and slave select clear
        finish    = 3'd5
    } seq_state_t;

endpackage

//--- logic/request_arbiter.sv
`timescale 1ns/1ps

module request_arbiter #(
    parameter int num_devices = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   clear,
    input  logic [num_devices-1:0] req,
    output logic [num_devices-1:0] grant
);

    logic [num_devices-1:0] lowest_req;

    // Two's complement trick isolates the lowest set bit,
    // so device 0 always wins
    assign lowest_req = req & (~req + 1'b1);

    // Grant only moves while enabled, otherwise it holds for the transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= '0;
        end else if (clear) begin
            grant <= '0;
        end else if (enable) begin
            grant <= lowest_req;
        end
    end

    // Never more than one master owns the bus
    grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grant)
    ) else $error("arbiter granted more than one master: %b", grant);

endmodule

//--- logic/address_translator.sv
`timescale 1ns/1ps

module address_translator #(
    parameter int num_devices = 8
) (
    input  bus_word_pkg::bus_word_t virt_addr,
    output bus_word_pkg::bus_word_t phys_addr,
    output logic [num_devices-1:0]  dev_select
);

    logic [bus_word_pkg::dev_index_width-1:0] dev_index;

    assign dev_index = virt_addr.addr.dev_index;

    // Slave sees only the offset, device field zeroed
    always_comb begin
        phys_addr.addr.dev_index = '0;
        phys_addr.addr.offset    = virt_addr.addr.offset;
    end

    // One-hot decode of the device field.
    // Indices past num_devices match nothing and leave the select empty
    always_comb begin
        dev_select = '0;
        for (int i = 0; i < num_devices; i++) begin
            if (int'(dev_index) == i) begin
                dev_select[i] = 1'b1;
            end
        end
    end

endmodule

//--- logic/device_select_mux.sv
`timescale 1ns/1ps

module device_select_mux #(
    parameter int num_devices = 8,
    parameter int word_width  = 32
) (
    input  logic [num_devices-1:0]                 sel,
    input  logic [num_devices-1:0][word_width-1:0] words,
    output logic [word_width-1:0]                  out
);

    // AND-OR select with each word masked by its own select bit
    always_comb begin
        out = '0;
        for (int i = 0; i < num_devices; i++) begin
            out |= words[i] & {word_width{sel[i]}};
        end
    end

    // Two set bits would OR two devices' words together
    always_comb begin
        sel_onehot: assert final ($onehot0(sel))
            else $error("mux select not one-hot: %b", sel);
    end

endmodule

//--- logic/transfer_sequencer.sv
`timescale 1ns/1ps

module transfer_sequencer #(
    parameter int num_devices = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [num_devices-1:0]     req,
    input  logic [num_devices-1:0]     grant,
    input  logic [num_devices-1:0]     dev_select,
    input  bus_ctrl_pkg::ctrl_fields_t master_ctrl,
    output logic                       arb_enable,
    output logic                       arb_clear,
    output logic [num_devices-1:0]     slave_en,
    output logic [num_devices-1:0]     data_sel,
    output logic [num_devices-1:0]     ctrl_sel,
    output logic                       addr_phase,
    output logic                       hold_addr,
    output logic                       force_ctrl,
    output logic                       latched_we,
    output logic [2:0]                 latched_burst
);

    bus_ctrl_pkg::seq_state_t state;
    bus_ctrl_pkg::seq_state_t next_state;

    logic slave_load;
    logic slave_clear;
    logic data_from_slave;
    logic ctrl_from_slave;
    logic req_dropped;

    // Grant still points at the initiating master during the transfer
    assign req_dropped = (req & grant) == '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= bus_ctrl_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // Next state and per-state controls
    always_comb begin
        next_state      = state;
        arb_enable      = 1'b0;
        arb_clear       = 1'b0;
        slave_load      = 1'b0;
        slave_clear     = 1'b0;
        data_from_slave = 1'b0;
        ctrl_from_slave = 1'b0;
        addr_phase      = 1'b0;
        hold_addr       = 1'b0;
        force_ctrl      = 1'b0;
        case (state)
            bus_ctrl_pkg::idle: begin
                arb_enable = 1'b1;
                addr_phase = 1'b1;
                if (req != '0) begin
                    next_state = bus_ctrl_pkg::ack;
                end
            end
            bus_ctrl_pkg::ack: begin
                addr_phase = 1'b1;
                next_state = bus_ctrl_pkg::addr;
            end
            bus_ctrl_pkg::addr: begin
                addr_phase = 1'b1;
                slave_load = 1'b1;
                next_state = bus_ctrl_pkg::ack_slave;
            end
            bus_ctrl_pkg::ack_slave: begin
                // Slave gets one more look at the address
                hold_addr       = 1'b1;
                force_ctrl      = 1'b1;
                ctrl_from_slave = 1'b1;
                next_state      = bus_ctrl_pkg::busy;
            end
            bus_ctrl_pkg::busy: begin
                data_from_slave = !latched_we;
                ctrl_from_slave = 1'b1;
                if (req_dropped) begin
                    next_state = bus_ctrl_pkg::finish;
                end
            end
            bus_ctrl_pkg::finish: begin
                data_from_slave = !latched_we;
                ctrl_from_slave = 1'b1;
                arb_clear       = 1'b1;
                slave_clear     = 1'b1;
                next_state      = bus_ctrl_pkg::idle;
            end
            default: begin
                next_state = bus_ctrl_pkg::idle;
            end
        endcase
    end

    // Slave select register
    always_ff @(posedge clk) begin
        if (reset) begin
            slave_en <= '0;
        end else if (slave_clear) begin
            slave_en <= '0;
        end else if (slave_load) begin
            slave_en <= dev_select;
        end
    end

    // Direction and burst from the master's control word
    always_ff @(posedge clk) begin
        if (state == bus_ctrl_pkg::ack) begin
            latched_we    <= master_ctrl.we;
            latched_burst <= master_ctrl.burst;
        end
    end

    assign data_sel = data_from_slave ? slave_en : grant;
    assign ctrl_sel = ctrl_from_slave ? slave_en : grant;

    state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {bus_ctrl_pkg::idle, bus_ctrl_pkg::ack, bus_ctrl_pkg::addr,
                      bus_ctrl_pkg::ack_slave, bus_ctrl_pkg::busy, bus_ctrl_pkg::finish}
    ) else $error("sequencer in illegal state %0d", state);

    // No slave stays selected once a transfer has wound down
    idle_no_slave: assert property (
        @(posedge clk) disable iff (reset)
        state == bus_ctrl_pkg::idle |-> slave_en == '0
    ) else $error("slave_en %b set in idle", slave_en);

endmodule

//--- logic/bus_controller.sv
`timescale 1ns/1ps

module bus_controller #(
    parameter int num_devices = 8
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [num_devices-1:0]                       req,
    input  bus_word_pkg::bus_word_t [num_devices-1:0]    bus_in,
    input  bus_ctrl_pkg::ctrl_fields_t [num_devices-1:0] ctrl_in,
    output logic [num_devices-1:0]                       master_ack,
    output logic [num_devices-1:0]                       slave_en,
    output bus_word_pkg::bus_word_t                      bus_out,
    output bus_ctrl_pkg::ctrl_fields_t                   ctrl_out
);

    if (num_devices < 2 || num_devices > bus_word_pkg::max_devices) begin : g_bad_count
        $error("num_devices %0d outside 2..%0d", num_devices, bus_word_pkg::max_devices);
    end

    logic [num_devices-1:0]     grant;
    logic [num_devices-1:0]     dev_select;
    logic [num_devices-1:0]     data_sel;
    logic [num_devices-1:0]     ctrl_sel;
    logic                       arb_enable;
    logic                       arb_clear;
    logic                       addr_phase;
    logic                       hold_addr;
    logic                       force_ctrl;
    logic                       latched_we;
    logic [2:0]                 latched_burst;
    bus_word_pkg::bus_word_t    data_mux_out;
    bus_word_pkg::bus_word_t    phys_addr;
    bus_word_pkg::bus_word_t    held_word;
    bus_ctrl_pkg::ctrl_fields_t ctrl_mux_out;
    bus_ctrl_pkg::ctrl_fields_t forced_ctrl;

    request_arbiter #(.num_devices(num_devices)) u_arbiter (
        .clk    (clk),
        .reset  (reset),
        .enable (arb_enable),
        .clear  (arb_clear),
        .req    (req),
        .grant  (grant)
    );

    assign master_ack = grant;

    device_select_mux #(
        .num_devices (num_devices),
        .word_width  (bus_word_pkg::data_width)
    ) u_data_mux (
        .sel   (data_sel),
        .words (bus_in),
        .out   (data_mux_out)
    );

    device_select_mux #(
        .num_devices (num_devices),
        .word_width  (bus_ctrl_pkg::ctrl_width)
    ) u_ctrl_mux (
        .sel   (ctrl_sel),
        .words (ctrl_in),
        .out   (ctrl_mux_out)
    );

    address_translator #(.num_devices(num_devices)) u_translator (
        .virt_addr  (data_mux_out),
        .phys_addr  (phys_addr),
        .dev_select (dev_select)
    );

    transfer_sequencer #(.num_devices(num_devices)) u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .grant         (grant),
        .dev_select    (dev_select),
        .master_ctrl   (ctrl_mux_out),
        .arb_enable    (arb_enable),
        .arb_clear     (arb_clear),
        .slave_en      (slave_en),
        .data_sel      (data_sel),
        .ctrl_sel      (ctrl_sel),
        .addr_phase    (addr_phase),
        .hold_addr     (hold_addr),
        .force_ctrl    (force_ctrl),
        .latched_we    (latched_we),
        .latched_burst (latched_burst)
    );

    // Last cycle's bus word, replayed while the slave is being selected
    always_ff @(posedge clk) begin
        held_word <= bus_out;
    end

    always_comb begin
        if (hold_addr) begin
            bus_out = held_word;
        end else if (addr_phase) begin
            bus_out = phys_addr;
        end else begin
            bus_out = data_mux_out;
        end
    end

    // Wait asserted toward the slave along with the transfer attributes
    always_comb begin
        forced_ctrl.reserved  = '0;
        forced_ctrl.burst     = latched_burst;
        forced_ctrl.we        = latched_we;
        forced_ctrl.wait_flag = 1'b1;
    end

    assign ctrl_out = force_ctrl ? forced_ctrl : ctrl_mux_out;

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int period       = 4,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    // Reset drops on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- bench/bus_controller_tb.sv
`timescale 1ns/1ps

module bus_controller_tb;

    localparam int num_devices         = 8;
    localparam int clk_period          = 4;
    localparam int cycles_per_transfer = 40;

    logic                                         clk;
    logic                                         reset;
    logic [num_devices-1:0]                       req;
    bus_word_pkg::bus_word_t [num_devices-1:0]    bus_in;
    bus_ctrl_pkg::ctrl_fields_t [num_devices-1:0] ctrl_in;
    logic [num_devices-1:0]                       master_ack;
    logic [num_devices-1:0]                       slave_en;
    bus_word_pkg::bus_word_t                      bus_out;
    bus_ctrl_pkg::ctrl_fields_t                   ctrl_out;

    // One entry per line of the data file
    int          t_master[$];
    logic        t_we[$];
    logic [2:0]  t_burst[$];
    logic [31:0] t_addr[$];
    logic [31:0] t_mdata[$];
    logic [31:0] t_sdata[$];
    int          t_early[$];

    integer                 seed   = 66;
    logic                   loaded = 1'b0;
    // Devices acting as master or slave get no noise
    logic [num_devices-1:0] in_use;

    clock_gen #(.period(clk_period), .reset_cycles(10)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    bus_controller #(.num_devices(num_devices)) u_dut (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .bus_in     (bus_in),
        .ctrl_in    (ctrl_in),
        .master_ack (master_ack),
        .slave_en   (slave_en),
        .bus_out    (bus_out),
        .ctrl_out   (ctrl_out)
    );

    task automatic abort_run(input string why);
        $display("TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string what, input bus_word_pkg::bus_word_t got,
                              input bus_word_pkg::bus_word_t expected);
        if (got !== expected) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got.data, expected.data);
            abort_run("bus word mismatch");
        end
    endtask

    task automatic check_ctrl(input string what, input bus_ctrl_pkg::ctrl_fields_t got,
                              input bus_ctrl_pkg::ctrl_fields_t expected);
        if (got !== expected) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, expected);
            abort_run("control word mismatch");
        end
    endtask

    task automatic check_select(input string what, input logic [num_devices-1:0] got,
                                input logic [num_devices-1:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, expected);
            abort_run("select vector mismatch");
        end
    endtask

    function automatic logic [num_devices-1:0] one_hot(input int index);
        logic [num_devices-1:0] v;
        v        = '0;
        v[index] = 1'b1;
        return v;
    endfunction

    // Fixed priority with device 0 first
    function automatic logic [num_devices-1:0] lowest_request(input logic [num_devices-1:0] r);
        logic [num_devices-1:0] v;
        v = '0;
        for (int i = num_devices - 1; i >= 0; i--) begin
            if (r[i]) begin
                v = one_hot(i);
            end
        end
        return v;
    endfunction

    function automatic bus_ctrl_pkg::ctrl_fields_t random_ctrl();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic drive_noise();
        for (int i = 0; i < num_devices; i++) begin
            if (!in_use[i]) begin
                bus_in[i].data = $random(seed);
                ctrl_in[i]     = random_ctrl();
            end
        end
    endtask

    task automatic load_transfers();
        int             fd;
        int             n;
        logic [31:0]    f[7];
        logic [8*256:1] skipped;
        fd = $fopen("bench/transfer_input.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/transfer_input.txt");
            abort_run("missing data file");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (n == 7) begin
                t_master.push_back(f[0]);
                t_we.push_back(f[1][0]);
                t_burst.push_back(f[2][2:0]);
                t_addr.push_back(f[3]);
                t_mdata.push_back(f[4]);
                t_sdata.push_back(f[5]);
                t_early.push_back(f[6]);
            end else begin
                // Comment line or trailing text
                n = $fgets(skipped, fd);
            end
        end
        $fclose(fd);
        if (t_master.size() == 0) begin
            $display("no transfers found in bench/transfer_input.txt");
            abort_run("empty data file");
        end
    endtask

    // Master puts its request, virtual address and control word on the bus
    task automatic raise_request(input int k);
        int m;
        m                = t_master[k];
        req[m]           = 1'b1;
        in_use[m]        = 1'b1;
        bus_in[m].data   = t_addr[k];
        ctrl_in[m]       = '0;
        ctrl_in[m].burst = t_burst[k];
        ctrl_in[m].we    = t_we[k];
    endtask

    task automatic run_transfer(input int k);
        int                         m;
        int                         s;
        int                         busy_cycles;
        bus_word_pkg::bus_word_t    phys;
        bus_word_pkg::bus_word_t    data_exp;
        bus_ctrl_pkg::ctrl_fields_t forced;
        m                = t_master[k];
        s                = t_addr[k][31:29];
        phys.data        = {3'b000, t_addr[k][28:0]};
        data_exp.data    = t_we[k] ? t_mdata[k] : t_sdata[k];
        forced           = '0;
        forced.burst     = t_burst[k];
        forced.we        = t_we[k];
        forced.wait_flag = 1'b1;
        busy_cycles      = 1 + ($unsigned($random(seed)) % 6);
        // A request raised in busy needs a later busy cycle to show the grant holding
        if (t_early[k] == 2 && busy_cycles < 2) begin
            busy_cycles = 2;
        end
        // A pending master already holds its request
        if (!req[m]) begin
            raise_request(k);
        end
        if (t_early[k] == 1) begin
            raise_request(k + 1);
        end
        @(negedge clk);
        while (master_ack == '0) begin
            @(negedge clk);
        end
        check_select("master_ack at grant", master_ack, lowest_request(req));
        @(negedge clk);
        check_word("bus_out in address phase", bus_out, phys);
        check_select("slave_en in address phase", slave_en, '0);
        @(negedge clk);
        check_select("slave_en after select", slave_en, one_hot(s));
        check_word("held address", bus_out, phys);
        check_ctrl("forced control", ctrl_out, forced);
        in_use[s]      = 1'b1;
        bus_in[s].data = t_sdata[k];
        bus_in[m].data = t_mdata[k];
        ctrl_in[s]     = random_ctrl();
        drive_noise();
        for (int i = 1; i <= busy_cycles; i++) begin
            @(negedge clk);
            check_select("master_ack in busy", master_ack, one_hot(m));
            check_select("slave_en in busy", slave_en, one_hot(s));
            check_word("bus_out in busy", bus_out, data_exp);
            check_ctrl("ctrl_out in busy", ctrl_out, ctrl_in[s]);
            // Higher priority request arriving mid transfer
            if (i == 1 && t_early[k] == 2) begin
                raise_request(k + 1);
            end
            ctrl_in[s] = random_ctrl();
            drive_noise();
        end
        req[m] = 1'b0;
        repeat (2) @(negedge clk);
        check_select("master_ack after release", master_ack, '0);
        check_select("slave_en after release", slave_en, '0);
        in_use[m] = 1'b0;
        in_use[s] = 1'b0;
        drive_noise();
    endtask

    initial begin
        req     = '0;
        bus_in  = '0;
        ctrl_in = '0;
        in_use  = '0;
        load_transfers();
        loaded = 1'b1;
        @(negedge reset);
        drive_noise();
        repeat (5) begin
            @(negedge clk);
            check_select("master_ack with no request", master_ack, '0);
            check_select("slave_en with no request", slave_en, '0);
            drive_noise();
        end
        for (int k = 0; k < t_master.size(); k++) begin
            run_transfer(k);
        end
        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog budget grows with the number of transfers
    initial begin
        wait (loaded);
        repeat (t_master.size() * cycles_per_transfer + 30) @(posedge clk);
        $display("transfer did not finish in the allowed number of cycles");
        abort_run("timeout");
    end

endmodule

//--- all.f
logic/bus_word_pkg.sv
logic/bus_ctrl_pkg.sv
logic/request_arbiter.sv
logic/address_translator.sv
logic/device_select_mux.sv
logic/transfer_sequencer.sv
logic/bus_controller.sv
bench/clock_gen.sv
bench/bus_controller_tb.sv

//--- bench/transfer_input.txt
# master  write  burst  virt_addr  master_data  slave_data  next_request
# next_request: 0 at its own start, 1 raised with this master, 2 raised during busy
0 1 3 60001234 A5A50001 5A5A0001 0
2 0 5 9ABC0010 A5A50002 5A5A0002 1
5 1 7 30000FF0 A5A50003 5A5A0003 2
0 0 1 E1234567 A5A50004 5A5A0004 0
7 1 0 20000004 A5A50005 5A5A0005 0
1 0 2 4FFFFFFC A5A50006 5A5A0006 1
6 1 4 10000100 A5A50007 5A5A0007 1
7 0 6 C0008000 A5A50008 5A5A0008 2
3 1 5 B00DF00D A5A50009 5A5A0009 0
4 0 3 77654321 A5A5000A 5A5A000A 0
2 1 1 D555AAAA A5A5000B 5A5A000B 1
3 0 7 00000000 A5A5000C 5A5A000C 0
6 1 2 FFFFFFFF A5A5000D 5A5A000D 0
